// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = tcb_sub_tb
FILELIST  = build.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

# build the simulation executable from the file list
compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# run and look for the pass line, failing status otherwise
run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf $(OBJ_DIR)

// File: build.f
+incdir+source
source/tcb_pkg.sv
source/tcb_req_stage.sv
source/tcb_mem.sv
source/tcb_rsp_pipe.sv
source/tcb_sub_top.sv
verification/tcb_sub_tb.sv

// File: source/tcb_defs.svh
`ifndef TCB_DEFS_SVH
`define TCB_DEFS_SVH

//////////////////////////////////////////////////////////////////////
// bus geometry
//////////////////////////////////////////////////////////////////////

// data bus width in bits
`define TCB_DAT_W 32
// one enable per data byte
`define TCB_BEN_W (`TCB_DAT_W/8)
// byte address width
`define TCB_ADR_W 16

//////////////////////////////////////////////////////////////////////
// subordinate defaults
//////////////////////////////////////////////////////////////////////

// memory size in words
`define TCB_MEM_DEPTH 256
// wait states before rdy
`define TCB_WAIT 1
// response delay in clock edges, counted from the transfer edge
`define TCB_DLY 2

`endif

// File: source/tcb_mem.sv
`timescale 1ns/1ps
`include "tcb_defs.svh"

module tcb_mem
  import tcb_pkg::*;
(
  input  logic     bus,
  input  logic     arst_n,
  // transfer strobe and request
  input  logic     trn,
  input  tcb_req_t req,
  // response for the current transfer
  output tcb_rsp_t rsp,
  output logic     stb
);

  // byte offset bits inside a word
  localparam int unsigned OFS_W = $clog2(`TCB_BEN_W);
  // word index bits
  localparam int unsigned IDX_W = $clog2(`TCB_MEM_DEPTH);
  // word address bits from the byte address
  localparam int unsigned WRD_W = `TCB_ADR_W - OFS_W;

  //////////////////////////////////////////////////////////////////////
  // storage
  //////////////////////////////////////////////////////////////////////

  // contents undefined until written
  logic [`TCB_DAT_W-1:0] mem [0:`TCB_MEM_DEPTH-1];

  //////////////////////////////////////////////////////////////////////
  // address decode
  //////////////////////////////////////////////////////////////////////

  logic [WRD_W-1:0] adr_wrd;
  logic [IDX_W-1:0] idx;
  logic             out_rng;
  logic             mis_aln;
  logic             err;

  // drop the byte offset
  assign adr_wrd = req.adr[`TCB_ADR_W-1:OFS_W];
  // low bits of the word address select the row
  assign idx = adr_wrd[IDX_W-1:0];

  // past the last word
  assign out_rng = (adr_wrd >= WRD_W'(`TCB_MEM_DEPTH));
  // byte offset must be zero
  assign mis_aln = |req.adr[OFS_W-1:0];

  assign err = out_rng | mis_aln;

  //////////////////////////////////////////////////////////////////////
  // write port
  //////////////////////////////////////////////////////////////////////

  // one edge, only enabled bytes
  always_ff @(posedge bus) begin
    if (trn && req.wen && !err) begin
      for (int i = 0; i < `TCB_BEN_W; i++) begin
        if (req.ben[i]) begin
          mem[idx][8*i +: 8] <= req.wdt[8*i +: 8];
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // read port
  //////////////////////////////////////////////////////////////////////

  // combinational, valid in the transfer cycle
  always_comb begin
    rsp.err = err;
    if (req.wen || err) begin
      // nothing to return for writes and bad addresses
      rsp.rdt = '0;
    end else begin
      rsp.rdt = mem[idx];
    end
  end

  // response is sampled exactly on transfers
  assign stb = trn;

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  // an access without any enabled byte is a manager bug
  a_ben_set: assert property (
    @(posedge bus) disable iff (!arst_n) trn |-> (|req.ben)
  ) else $error("transfer with all byte enables low");

endmodule

// File: source/tcb_pkg.sv
`include "tcb_defs.svh"

package tcb_pkg;

  ////////////////////////////////////////////////////////////////////
  // request from the input side
  ////////////////////////////////////////////////////////////////////

  typedef struct packed {
    // write enable, read otherwise
    logic                  wen;
    // byte address
    logic [`TCB_ADR_W-1:0] adr;
    // byte enables
    logic [`TCB_BEN_W-1:0] ben;
    // write data
    logic [`TCB_DAT_W-1:0] wdt;
  } tcb_req_t;

  ////////////////////////////////////////////////////////////////////
  // response through the delay line
  ////////////////////////////////////////////////////////////////////

  typedef struct packed {
    // read data, zero on writes and errors
    logic [`TCB_DAT_W-1:0] rdt;
    // bad address
    logic                  err;
  } tcb_rsp_t;

  // 53 bit request, 33 bit response
  // with the default geometry

endpackage

// File: source/tcb_req_stage.sv
`timescale 1ns/1ps
`include "tcb_defs.svh"

module tcb_req_stage
  import tcb_pkg::*;
#(
  // wait states before rdy
  parameter int unsigned WAIT = `TCB_WAIT
)(
  input  logic                  bus,
  input  logic                  arst_n,
  // manager request
  input  logic                  vld,
  input  logic                  wen,
  input  logic [`TCB_ADR_W-1:0] adr,
  input  logic [`TCB_BEN_W-1:0] ben,
  input  logic [`TCB_DAT_W-1:0] wdt,
  // handshake back to the manager
  output logic                  rdy,
  // transfer strobe and request to the memory
  output logic                  trn,
  output tcb_req_t              req
);

  // at least one bit even with no wait states
  localparam int unsigned CNT_W = (WAIT > 0) ? $clog2(WAIT + 1) : 1;

  //////////////////////////////////////////////////////////////////////
  // wait state counter
  //////////////////////////////////////////////////////////////////////

  // cycles spent with vld high and no transfer
  logic [CNT_W-1:0] cnt;

  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      cnt <= '0;
    end else if (trn) begin
      // next request starts from scratch
      cnt <= '0;
    end else if (vld) begin
      // stops by itself, rdy forces trn once cnt reaches WAIT
      cnt <= cnt + 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // handshake
  //////////////////////////////////////////////////////////////////////

  // ready once enough wait states went by
  // always ready without wait states
  assign rdy = (cnt == WAIT);

  // transfer cycle
  assign trn = vld & rdy;

  // request fields packed for the memory
  always_comb begin
    req.wen = wen;
    req.adr = adr;
    req.ben = ben;
    req.wdt = wdt;
  end

  //////////////////////////////////////////////////////////////////////
  // protocol checks
  //////////////////////////////////////////////////////////////////////

  // a pending request must not change or be withdrawn
  property p_req_hold;
    @(posedge bus) disable iff (!arst_n)
      (vld && !trn) |=> (vld && $stable(wen) && $stable(adr) &&
                         $stable(ben) && $stable(wdt));
  endproperty

  a_req_hold: assert property (p_req_hold)
    else $error("request changed while waiting for rdy");

  // counter bounded through the handshake
  a_cnt_max: assert property (
    @(posedge bus) disable iff (!arst_n) cnt <= WAIT
  ) else $error("wait state counter above %0d", WAIT);

endmodule

// File: source/tcb_rsp_pipe.sv
`timescale 1ns/1ps
`include "tcb_defs.svh"

module tcb_rsp_pipe
  import tcb_pkg::*;
#(
  // response delay in clock edges, at least 1
  parameter int unsigned DLY = `TCB_DLY
)(
  input  logic                  bus,
  input  logic                  arst_n,
  // response from the memory
  input  logic                  stb,
  input  tcb_rsp_t              rsp,
  // delayed response to the manager
  output logic [`TCB_DAT_W-1:0] rdt,
  output logic                  err
);

  //////////////////////////////////////////////////////////////////////
  // delay line
  //////////////////////////////////////////////////////////////////////

  // one stage per edge, so DLY responses in flight
  tcb_rsp_t dly_q [0:DLY-1];

  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      // outputs read zero after reset
      for (int i = 0; i < DLY; i++) begin
        dly_q[i] <= '0;
      end
    end else begin
      // idle cycles push a zero response
      if (stb) begin
        dly_q[0] <= rsp;
      end else begin
        dly_q[0] <= '0;
      end
      // shift toward the output
      for (int i = 1; i < DLY; i++) begin
        dly_q[i] <= dly_q[i-1];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // outputs
  //////////////////////////////////////////////////////////////////////

  // last stage straight to the bus
  assign rdt = dly_q[DLY-1].rdt;
  assign err = dly_q[DLY-1].err;

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  // error responses carry no data, set by the memory DLY edges back
  a_err_zero: assert property (
    @(posedge bus) disable iff (!arst_n) err |-> (rdt == '0)
  ) else $error("err high with rdt %h", rdt);

endmodule

// File: source/tcb_sub_top.sv
`timescale 1ns/1ps
`include "tcb_defs.svh"

module tcb_sub_top
  import tcb_pkg::*;
#(
  // wait states before rdy
  parameter int unsigned WAIT = `TCB_WAIT,
  // response delay in edges
  parameter int unsigned DLY  = `TCB_DLY
)(
  input  logic                  bus,
  input  logic                  arst_n,
  // request
  input  logic                  vld,
  input  logic                  wen,
  input  logic [`TCB_ADR_W-1:0] adr,
  input  logic [`TCB_BEN_W-1:0] ben,
  input  logic [`TCB_DAT_W-1:0] wdt,
  // handshake and response
  output logic                  rdy,
  output logic [`TCB_DAT_W-1:0] rdt,
  output logic                  err
);

  // input side to memory
  logic     trn;
  tcb_req_t req;
  // memory to delay line
  tcb_rsp_t rsp;
  logic     stb;

  //////////////////////////////////////////////////////////////////////
  // request, memory, response
  //////////////////////////////////////////////////////////////////////

  tcb_req_stage #(.WAIT(WAIT)) tcb_req_stage_inst (
    .bus(bus), .arst_n(arst_n), .vld(vld), .wen(wen), .adr(adr),
    .ben(ben), .wdt(wdt), .rdy(rdy), .trn(trn), .req(req)
  );

  tcb_mem tcb_mem_inst (
    .bus(bus), .arst_n(arst_n), .trn(trn), .req(req), .rsp(rsp), .stb(stb)
  );

  tcb_rsp_pipe #(.DLY(DLY)) tcb_rsp_pipe_inst (
    .bus(bus), .arst_n(arst_n), .stb(stb), .rsp(rsp), .rdt(rdt), .err(err)
  );

endmodule

// File: verification/tcb_sub_tb.sv
`timescale 1ns/1ps
`include "tcb_defs.svh"

module tcb_sub_tb;

  localparam int unsigned WAIT = 1;
  localparam int unsigned DLY = 2;
  localparam int unsigned ADR_W = `TCB_ADR_W;
  localparam int unsigned OFS = $clog2(`TCB_BEN_W);
  // words touched by the data tests
  localparam int unsigned WORDS = 16;
  // roughly 300 cycles of traffic with a wide margin
  localparam int unsigned MAX_CYC = 4000;

  logic                  bus;
  logic                  arst_n;
  logic                  vld;
  logic                  wen;
  logic [`TCB_ADR_W-1:0] adr;
  logic [`TCB_BEN_W-1:0] ben;
  logic [`TCB_DAT_W-1:0] wdt;
  logic                  rdy;
  logic [`TCB_DAT_W-1:0] rdt;
  logic                  err;

  tcb_sub_top #(.WAIT(WAIT), .DLY(DLY)) tcb_sub_top_inst (
    .bus(bus), .arst_n(arst_n), .vld(vld), .wen(wen), .adr(adr),
    .ben(ben), .wdt(wdt), .rdy(rdy), .rdt(rdt), .err(err)
  );

  //////////////////////////////////////////////////////////////////////
  // reference model state
  //////////////////////////////////////////////////////////////////////

  logic [`TCB_DAT_W-1:0] ref_mem [0:`TCB_MEM_DEPTH-1];
  // pending responses as due cycle and payload
  int unsigned           due_q [$];
  logic [`TCB_DAT_W-1:0] rdt_q [$];
  logic                  err_q [$];
  // cycles of the current request spent waiting
  int unsigned           wait_run = 0;
  // expected bus outputs for the running cycle
  logic                  exp_rdy = 1'b0;
  logic [`TCB_DAT_W-1:0] exp_rdt = '0;
  logic                  exp_err = 1'b0;
  int unsigned           cyc = 0;
  int unsigned           err_cnt = 0;
  int unsigned           rsp_cnt = 0;
  // model scratch
  int unsigned           wrd;
  logic                  bad;
  logic [`TCB_DAT_W-1:0] new_rdt;

  // byte-wise update of a stored word
  function automatic logic [`TCB_DAT_W-1:0] merge_bytes(
    input logic [`TCB_DAT_W-1:0] old_w,
    input logic [`TCB_DAT_W-1:0] new_w,
    input logic [`TCB_BEN_W-1:0] en
  );
    logic [`TCB_DAT_W-1:0] res;
    res = old_w;
    for (int i = 0; i < `TCB_BEN_W; i++) begin
      if (en[i]) begin
        res[8*i +: 8] = new_w[8*i +: 8];
      end
    end
    return res;
  endfunction

  // byte address of a word
  function automatic logic [`TCB_ADR_W-1:0] word_adr(input int unsigned idx);
    return ADR_W'(idx << OFS);
  endfunction

  // any nonzero byte enable pattern
  function automatic logic [`TCB_BEN_W-1:0] rand_ben();
    return `TCB_BEN_W'($urandom_range(1, (1 << `TCB_BEN_W) - 1));
  endfunction

  //////////////////////////////////////////////////////////////////////
  // clock, cycle count, timeout
  //////////////////////////////////////////////////////////////////////

  initial begin
    bus = 1'b0;
    forever #4 bus = ~bus;
  end

  always @(posedge bus) begin
    cyc <= cyc + 1;
  end

  initial begin
    wait (cyc >= MAX_CYC);
    $display("timeout, run did not finish within %0d cycles", MAX_CYC);
    $display("sim failed");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  // evaluated mid cycle once inputs and outputs settled
  always @(negedge bus) begin
    if (!arst_n) begin
      wait_run = 0;
      exp_rdy = 1'b0;
      exp_rdt = '0;
      exp_err = 1'b0;
      due_q.delete();
      rdt_q.delete();
      err_q.delete();
    end else begin
      // ready after WAIT waiting cycles
      exp_rdy = (wait_run == WAIT);
      if (vld && exp_rdy) begin
        wrd = int'(adr >> OFS);
        // beyond the memory or not word aligned
        bad = (wrd >= `TCB_MEM_DEPTH) || (adr[OFS-1:0] != '0);
        new_rdt = (wen || bad) ? '0 : ref_mem[wrd];
        if (wen && !bad) begin
          ref_mem[wrd] = merge_bytes(ref_mem[wrd], wdt, ben);
        end
        // visible DLY edges after this transfer edge
        due_q.push_back(cyc + DLY);
        rdt_q.push_back(new_rdt);
        err_q.push_back(bad);
        wait_run = 0;
      end else if (vld) begin
        wait_run++;
      end
      // idle cycles expect a zero response
      if (due_q.size() > 0 && due_q[0] == cyc) begin
        void'(due_q.pop_front());
        exp_rdt = rdt_q.pop_front();
        exp_err = err_q.pop_front();
        rsp_cnt++;
      end else begin
        exp_rdt = '0;
        exp_err = 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  // wait states never early and never late
  a_rdy: assert property (@(posedge bus) disable iff (!arst_n) rdy == exp_rdy)
    else begin
      err_cnt++;
      $display("ERROR rdy: expected %h, actual %h", exp_rdy, $sampled(rdy));
    end

  // read data at the fixed delay and zero when idle
  a_rdt: assert property (@(posedge bus) disable iff (!arst_n) rdt == exp_rdt)
    else begin
      err_cnt++;
      $display("ERROR rdt: expected %h, actual %h", exp_rdt, $sampled(rdt));
    end

  a_err: assert property (@(posedge bus) disable iff (!arst_n) err == exp_err)
    else begin
      err_cnt++;
      $display("ERROR err: expected %h, actual %h", exp_err, $sampled(err));
    end

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  // holds the request until rdy is seen and returns 1 ns past the transfer edge
  task automatic send_req(
    input logic                  w,
    input logic [`TCB_ADR_W-1:0] a,
    input logic [`TCB_BEN_W-1:0] b,
    input logic [`TCB_DAT_W-1:0] d
  );
    logic done;
    vld = 1'b1;
    wen = w;
    adr = a;
    ben = b;
    wdt = d;
    done = 1'b0;
    while (!done) begin
      @(negedge bus);
      done = rdy;
      @(posedge bus);
      #1;
    end
  endtask

  task automatic pause(input int unsigned n);
    vld = 1'b0;
    repeat (n) begin
      @(posedge bus);
      #1;
    end
  endtask

  initial begin
    int unsigned k;
    void'($urandom(32'h4a14));
    arst_n = 1'b0;
    vld = 1'b0;
    wen = 1'b0;
    adr = '0;
    ben = '0;
    wdt = '0;
    repeat (3) @(posedge bus);
    #1;
    arst_n = 1'b1;

    // quiet bus right after reset
    pause(4);

    // full words first so every read hits known data
    for (int i = 0; i < WORDS; i++) begin
      send_req(1'b1, word_adr(i), '1, $urandom());
    end
    // partial updates
    repeat (24) begin
      send_req(1'b1, word_adr($urandom_range(0, WORDS - 1)), rand_ben(), $urandom());
    end
    // back-to-back readback
    for (int i = 0; i < WORDS; i++) begin
      send_req(1'b0, word_adr(i), rand_ben(), $urandom());
    end
    // reads with idle gaps and rdt back to zero in between
    repeat (12) begin
      send_req(1'b0, word_adr($urandom_range(0, WORDS - 1)), rand_ben(), $urandom());
      pause($urandom_range(1, 3));
    end

    ////////////////////////////////////////////////////////////////////
    // error accesses
    ////////////////////////////////////////////////////////////////////

    repeat (4) begin
      k = $urandom_range(0, WORDS - 1);
      // out of range word that aliases onto word k without the check
      send_req(1'b1, word_adr(k + `TCB_MEM_DEPTH), '1, $urandom());
      // misaligned onto word k
      send_req(1'b1, word_adr(k) + ADR_W'($urandom_range(1, `TCB_BEN_W - 1)), '1,
               $urandom());
      // word k unchanged
      send_req(1'b0, word_adr(k), rand_ben(), $urandom());
      // bad reads return nothing
      send_req(1'b0, word_adr(k + `TCB_MEM_DEPTH), rand_ben(), $urandom());
      send_req(1'b0, word_adr(k) + ADR_W'($urandom_range(1, `TCB_BEN_W - 1)),
               rand_ben(), $urandom());
      pause(1);
    end
    send_req(1'b0, '1, rand_ben(), $urandom());

    // drain the response pipeline
    pause(DLY + 3);
    $display("checked %0d responses, %0d errors", rsp_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule
